// ==== src/bk_config.svh ====
// backup RAM size, sector count and bus width macros
`ifndef BK_CONFIG_SVH
`define BK_CONFIG_SVH

// game side byte port, 8 KB
`define BK_ADDR_W 13
`define BK_DATA_W 8

// sd side word width
`define BK_WORD_W 16

// word index inside one 512 byte sector
`define BK_BUF_ADDR_W 8

// sectors per save image
`define BK_SECTORS 16

// block address as seen by the sd host
`define BK_LBA_W 32

`endif

// ==== src/bk_pkg.sv ====
// wishbone and sd bus structs, operation and sequencer state enums
package bk_pkg;

	// game side request, wishbone classic
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [12:0] adr;
		logic [7:0]  dat;
	} wb_req_t;

	// game side response
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// block request to the sd host
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// buffer access driven by the host while ack is high
	typedef struct packed {
		logic [7:0]  addr;
		logic [15:0] dout;
		logic        wr;
	} sd_buf_t;

	typedef enum logic {BK_OP_LOAD, BK_OP_SAVE} bk_op_e;

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_REQ, SEQ_XFER, SEQ_NEXT} seq_state_e;

endpackage

// ==== src/bk_mem.sv ====
// backup memory with a byte wide wishbone port and a 16-bit sd buffer port
`include "bk_config.svh"

module bk_mem (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  bk_pkg::wb_req_t                wb_req,
	output bk_pkg::wb_rsp_t                wb_rsp,
	output logic                           wr_strobe,
	input  logic [$clog2(`BK_SECTORS)-1:0] lba_sel,
	input  logic                           sd_ack,
	input  bk_pkg::sd_buf_t                sd_buf,
	output logic [`BK_WORD_W-1:0]          sd_buff_din
);
	import bk_pkg::*;

	localparam int WADDR_W = `BK_ADDR_W - 1;
	localparam int WORDS   = 1 << WADDR_W;
	localparam int LANES   = `BK_WORD_W / `BK_DATA_W;

	// one entry per sd word, lane 0 is the even byte
	logic [LANES-1:0][`BK_DATA_W-1:0] mem [WORDS];

	logic [WADDR_W-1:0]    a_word;
	logic                  a_lane;
	logic                  a_req;
	logic [WADDR_W-1:0]    b_addr;
	logic                  b_wr;
	logic                  ack_q;
	logic [`BK_DATA_W-1:0] a_dat_q;

	// a held strobe is not taken twice
	assign a_req  = wb_req.cyc & wb_req.stb & ~ack_q;
	assign a_word = wb_req.adr[`BK_ADDR_W-1:1];
	assign a_lane = wb_req.adr[0];

	// sector select on top of the word index
	assign b_addr = {lba_sel, sd_buf.addr};
	assign b_wr   = sd_buf.wr & sd_ack;

	////////////////////////////////////////////////////////////
	// storage

	always_ff @(posedge clk_sys) begin
		if (a_req && wb_req.we)
			mem[a_word][a_lane] <= wb_req.dat;
		// port b last, so it wins a same word collision
		if (b_wr)
			mem[b_addr] <= sd_buf.dout;
		a_dat_q     <= mem[a_word][a_lane];
		sd_buff_din <= mem[b_addr];
	end

	////////////////////////////////////////////////////////////
	// wishbone handshake

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ack_q     <= 1'b0;
			wr_strobe <= 1'b0;
		end else begin
			ack_q     <= a_req;
			wr_strobe <= a_req & wb_req.we;
		end
	end

	assign wb_rsp = wb_rsp_t'{ack: ack_q, dat: a_dat_q};

	// the master drops its strobe once it has seen ack
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_rsp.ack |-> !wb_req.stb);

endmodule

// ==== src/bk_trigger.sv ====
// backup enable, command edge detection, save-pending flag and start decision
module bk_trigger (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  logic           img_mounted,
	input  logic           img_readonly,
	input  logic           cmd_load,
	input  logic           cmd_save,
	input  logic           autosave_en,
	input  logic           osd_status,
	input  logic           wr_strobe,
	input  logic           busy,
	output logic           start,
	output bk_pkg::bk_op_e op,
	output logic           bk_ena,
	output logic           sav_pending
);
	import bk_pkg::*;

	logic load_q;
	logic save_q;
	logic auto_q;
	logic auto_req;
	logic load_rise;
	logic save_rise;
	logic auto_rise;
	logic go;

	// autosave only counts while the menu is open
	assign auto_req  = autosave_en & osd_status;
	assign load_rise = cmd_load & ~load_q;
	assign save_rise = cmd_save & ~save_q;
	assign auto_rise = auto_req & ~auto_q;

	// busy is still low during the start cycle itself
	assign go = bk_ena & ~busy & ~start
		& (load_rise | save_rise | (auto_rise & sav_pending));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			auto_q      <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
			start       <= 1'b0;
		end else begin
			load_q <= cmd_load;
			save_q <= cmd_save;
			auto_q <= auto_req;
			// a read-only image disables backup again
			if (img_mounted)
				bk_ena <= ~img_readonly;
			start <= go;
			if (wr_strobe)
				sav_pending <= 1'b1;
			else if (go)
				sav_pending <= 1'b0;
		end
	end

	// load wins over save on the same edge
	always_ff @(posedge clk_sys) begin
		if (go)
			op <= load_rise ? BK_OP_LOAD : BK_OP_SAVE;
	end

endmodule

// ==== src/bk_sector_seq.sv ====
// sector sequencer issuing sd block reads or writes for sectors 0 to 15
`include "bk_config.svh"

module bk_sector_seq (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  logic                           start,
	input  bk_pkg::bk_op_e                 op,
	input  logic                           sd_ack,
	output bk_pkg::sd_req_t                sd_req,
	output logic [$clog2(`BK_SECTORS)-1:0] lba_sel,
	output logic                           busy
);
	import bk_pkg::*;

	localparam int SEL_W = $clog2(`BK_SECTORS);
	localparam int LBA_W = `BK_LBA_W;
	localparam logic [SEL_W-1:0] LAST = SEL_W'(`BK_SECTORS - 1);

	seq_state_e       state;
	seq_state_e       state_nx;
	logic [SEL_W-1:0] lba_q;
	logic             req;
	logic             ack_fall;

	// in XFER ack was high, so low here is its falling edge
	assign ack_fall = (state == SEQ_XFER) & ~sd_ack;

	////////////////////////////////////////////////////////////
	// state machine

	always_comb begin
		state_nx = state;
		case (state)
			// wait for the host to release ack before the first request
			SEQ_IDLE: if (start) state_nx = SEQ_NEXT;
			SEQ_NEXT: if (!sd_ack) state_nx = SEQ_REQ;
			// request held until ack is seen
			SEQ_REQ:  if (sd_ack) state_nx = SEQ_XFER;
			SEQ_XFER: begin
				if (ack_fall)
					state_nx = (lba_q == LAST) ? SEQ_IDLE : SEQ_REQ;
			end
			default:  state_nx = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			lba_q <= '0;
		end else begin
			state <= state_nx;
			if (state == SEQ_IDLE && start)
				lba_q <= '0;
			else if (ack_fall && lba_q != LAST)
				lba_q <= lba_q + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// outputs

	assign req     = (state == SEQ_REQ);
	assign busy    = (state != SEQ_IDLE);
	assign lba_sel = lba_q;

	assign sd_req = sd_req_t'{
		lba: LBA_W'(lba_q),
		rd:  req & (op == BK_OP_LOAD),
		wr:  req & (op == BK_OP_SAVE)
	};

	// a request stays up on the same block until the host acks
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(sd_req.rd || sd_req.wr) && !sd_ack |=> $stable(sd_req));

	// and drops in the cycle after the ack is seen
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(sd_req.rd || sd_req.wr) && sd_ack |=> !(sd_req.rd || sd_req.wr));

endmodule

// ==== src/bk_save_top.sv ====
// backup RAM save engine top with memory, trigger logic and sector sequencer
`include "bk_config.svh"

module bk_save_top (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	// game side
	input  bk_pkg::wb_req_t       wb_req,
	output bk_pkg::wb_rsp_t       wb_rsp,
	// image and menu controls
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  cmd_load,
	input  logic                  cmd_save,
	input  logic                  autosave_en,
	input  logic                  osd_status,
	// sd host
	output bk_pkg::sd_req_t       sd_req,
	input  logic                  sd_ack,
	input  bk_pkg::sd_buf_t       sd_buf,
	output logic [`BK_WORD_W-1:0] sd_buff_din,
	// status
	output logic                  busy,
	output logic                  bk_ena,
	output logic                  sav_pending
);
	import bk_pkg::*;

	logic                           wr_strobe;
	logic                           start;
	bk_op_e                         op;
	logic [$clog2(`BK_SECTORS)-1:0] lba_sel;

	bk_mem u_mem (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.wr_strobe   (wr_strobe),
		.lba_sel     (lba_sel),
		.sd_ack      (sd_ack),
		.sd_buf      (sd_buf),
		.sd_buff_din (sd_buff_din)
	);

	bk_trigger u_trigger (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.cmd_load     (cmd_load),
		.cmd_save     (cmd_save),
		.autosave_en  (autosave_en),
		.osd_status   (osd_status),
		.wr_strobe    (wr_strobe),
		.busy         (busy),
		.start        (start),
		.op           (op),
		.bk_ena       (bk_ena),
		.sav_pending  (sav_pending)
	);

	bk_sector_seq u_seq (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.start   (start),
		.op      (op),
		.sd_ack  (sd_ack),
		.sd_req  (sd_req),
		.lba_sel (lba_sel),
		.busy    (busy)
	);

endmodule

// ==== verif/clk_gen.sv ====
// testbench clock and power-on reset generator
module clk_gen (
	output logic clk_sys,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// held for 4 rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end
endmodule

// ==== verif/bk_checker.sv ====
// DUT port monitors, value compare tasks, sd request log and result counters
module bk_checker (
	input logic            clk_sys,
	input logic            rst_n,
	input bk_pkg::wb_req_t wb_req,
	input bk_pkg::wb_rsp_t wb_rsp,
	input bk_pkg::sd_req_t sd_req
);
	timeunit 1ns;
	timeprecision 1ps;
	import bk_pkg::*;

	int          checks = 0;
	int          errors = 0;
	int          test_errors = 0;
	string       test_name;
	logic        stb_q = 1'b0;
	logic        req_q = 1'b0;
	logic [31:0] lba_log[$];
	logic        rd_log[$];
	logic        wr_log[$];

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		checks++;
		errors++;
		$display("at %0t: %s", $time, what);
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors)
			$display("[test] %s: ok", test_name);
		else
			$display("[test] %s: %0d errors", test_name, errors - test_errors);
	endtask

	task automatic clear_requests();
		lba_log.delete();
		rd_log.delete();
		wr_log.delete();
	endtask

	function automatic int request_count();
		return lba_log.size();
	endfunction

	// one full image transfer, sectors in order
	task automatic check_requests(input logic exp_rd);
		check_val("sd request count", 32'd16, lba_log.size());
		for (int i = 0; i < lba_log.size(); i++) begin
			check_val("sd_req.lba", i, lba_log[i]);
			check_val("sd_req.rd", exp_rd, rd_log[i]);
			check_val("sd_req.wr", !exp_rd, wr_log[i]);
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, errors %0d", checks, errors);
	endtask

	////////////////////////////////////////////////////////////
	// monitors

	// strobe as the DUT samples it
	always @(posedge clk_sys)
		stb_q <= wb_req.cyc & wb_req.stb;

	always @(negedge clk_sys) begin
		if (rst_n && wb_rsp.ack && !stb_q)
			check_val("wb_rsp.ack", 32'd0, 32'd1);
	end

	// log the start of each sd request
	always @(negedge clk_sys) begin
		if (rst_n && (sd_req.rd || sd_req.wr) && !req_q) begin
			lba_log.push_back(sd_req.lba);
			rd_log.push_back(sd_req.rd);
			wr_log.push_back(sd_req.wr);
		end
		req_q = rst_n & (sd_req.rd | sd_req.wr);
	end
endmodule

// ==== verif/tb_top.sv ====
// testbench top with stimulus, wishbone master, sd host model and reference model
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;
	import bk_pkg::*;

	localparam int BYTES        = 8192;
	localparam int WB_TIMEOUT   = 8;
	localparam int IDLE_CYCLES  = 50;
	localparam int XFER_TIMEOUT = 20000;

	logic        clk_sys;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        img_mounted;
	logic        img_readonly;
	logic        cmd_load;
	logic        cmd_save;
	logic        autosave_en;
	logic        osd_status;
	sd_req_t     sd_req;
	logic        sd_ack;
	sd_buf_t     sd_buf;
	logic [15:0] sd_buff_din;
	logic        busy;
	logic        bk_ena;
	logic        sav_pending;
	logic [31:0] rng_state = 32'hd3ee7423;
	logic [7:0]  model_mem [BYTES];

	clk_gen u_clk (.clk_sys(clk_sys), .rst_n(rst_n));

	bk_save_top DUT (
		.clk_sys(clk_sys), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.img_mounted(img_mounted), .img_readonly(img_readonly),
		.cmd_load(cmd_load), .cmd_save(cmd_save),
		.autosave_en(autosave_en), .osd_status(osd_status),
		.sd_req(sd_req), .sd_ack(sd_ack), .sd_buf(sd_buf), .sd_buff_din(sd_buff_din),
		.busy(busy), .bk_ena(bk_ena), .sav_pending(sav_pending)
	);

	bk_checker u_chk (
		.clk_sys(clk_sys), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp), .sd_req(sd_req)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [7:0] fill_byte(input logic [12:0] a);
		return (a[7:0] * 8'd29) ^ {a[12:8], a[12:10]};
	endfunction

	// word w of sector s, even byte in the low half
	function automatic logic [15:0] expected_word(input int s, input int w);
		return {model_mem[512 * s + 2 * w + 1], model_mem[512 * s + 2 * w]};
	endfunction

	task automatic wb_access(input logic we, input logic [12:0] adr, input logic [7:0] dat,
		output logic [7:0] rdat);
		int n;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		@(negedge clk_sys);
		n = 1;
		while (!wb_rsp.ack && n < WB_TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!wb_rsp.ack)
			u_chk.report_failure("no wishbone ack arrived within the timeout");
		else
			u_chk.check_val("wb ack latency", 32'd1, n);
		rdat   = wb_rsp.dat;
		wb_req = '0;
		// let ack drop before the next strobe
		@(negedge clk_sys);
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (busy !== level)
			u_chk.report_failure({"timeout while waiting for ", what});
	endtask

	////////////////////////////////////////////////////////////
	// sd host, random ack delay, one sector per request

	initial begin
		int          s;
		logic        is_load;
		logic [31:0] r;
		sd_ack = 1'b0;
		sd_buf = '0;
		forever begin
			@(negedge clk_sys);
			if (rst_n && (sd_req.rd || sd_req.wr)) begin
				s       = sd_req.lba;
				is_load = sd_req.rd;
				r       = next_rand();
				repeat (r[1:0]) @(negedge clk_sys);
				sd_ack = 1'b1;
				for (int w = 0; w <= 256; w++) begin
					if (is_load && w < 256) begin
						r = next_rand();
						sd_buf = '{addr: 8'(w), dout: r[15:0], wr: 1'b1};
						model_mem[512 * s + 2 * w]     = r[7:0];
						model_mem[512 * s + 2 * w + 1] = r[15:8];
					end
					// read data lags the address by one cycle
					if (!is_load && w > 0)
						u_chk.check_val("sd_buff_din", expected_word(s, w - 1), sd_buff_din);
					if (!is_load && w < 256)
						sd_buf.addr = 8'(w);
					if (w < 256)
						@(negedge clk_sys);
				end
				sd_buf.wr = 1'b0;
				sd_ack    = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		logic [7:0]  rdat;
		logic [31:0] r;
		logic [12:0] adr_q[$];
		int          n;
		wb_req       = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		cmd_load     = 1'b0;
		cmd_save     = 1'b0;
		autosave_en  = 1'b0;
		osd_status   = 1'b0;
		n = 0;
		while (rst_n !== 1'b1 && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		@(negedge clk_sys);

		u_chk.begin_test("reset state and save before mount");
		u_chk.check_val("busy", 32'd0, busy);
		u_chk.check_val("sd_req.rd", 32'd0, sd_req.rd);
		u_chk.check_val("sd_req.wr", 32'd0, sd_req.wr);
		u_chk.check_val("bk_ena", 32'd0, bk_ena);
		u_chk.check_val("sav_pending", 32'd0, sav_pending);
		cmd_save = 1'b1;
		@(negedge clk_sys);
		cmd_save = 1'b0;
		repeat (IDLE_CYCLES) @(negedge clk_sys);
		u_chk.check_val("sd request count", 32'd0, u_chk.request_count());
		u_chk.end_test();

		u_chk.begin_test("wishbone write and read back");
		for (int a = 0; a < BYTES; a++) begin
			model_mem[a] = fill_byte(13'(a));
			wb_access(1'b1, 13'(a), model_mem[a], rdat);
		end
		for (int i = 0; i < 64; i++) begin
			r = next_rand();
			adr_q.push_back(r[12:0]);
			model_mem[r[12:0]] = r[23:16];
			wb_access(1'b1, r[12:0], r[23:16], rdat);
		end
		foreach (adr_q[i]) begin
			wb_access(1'b0, adr_q[i], 8'h00, rdat);
			u_chk.check_val("wb_rsp.dat", model_mem[adr_q[i]], rdat);
		end
		u_chk.check_val("sav_pending", 32'd1, sav_pending);
		u_chk.end_test();

		u_chk.begin_test("manual save");
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		@(negedge clk_sys);
		u_chk.check_val("bk_ena", 32'd1, bk_ena);
		u_chk.clear_requests();
		cmd_save = 1'b1;
		@(negedge clk_sys);
		cmd_save = 1'b0;
		wait_busy(1'b1, IDLE_CYCLES, "busy to rise after cmd_save");
		wait_busy(1'b0, XFER_TIMEOUT, "the save to finish");
		u_chk.check_requests(1'b0);
		u_chk.check_val("sav_pending", 32'd0, sav_pending);
		u_chk.end_test();

		u_chk.begin_test("manual load");
		u_chk.clear_requests();
		cmd_load = 1'b1;
		@(negedge clk_sys);
		cmd_load = 1'b0;
		wait_busy(1'b1, IDLE_CYCLES, "busy to rise after cmd_load");
		wait_busy(1'b0, XFER_TIMEOUT, "the load to finish");
		u_chk.check_requests(1'b1);
		for (int a = 0; a < BYTES; a++) begin
			wb_access(1'b0, 13'(a), 8'h00, rdat);
			u_chk.check_val("wb_rsp.dat", model_mem[a], rdat);
		end
		u_chk.end_test();

		u_chk.begin_test("autosave on menu open");
		u_chk.clear_requests();
		autosave_en = 1'b1;
		@(negedge clk_sys);
		osd_status = 1'b1;
		repeat (IDLE_CYCLES) @(negedge clk_sys);
		u_chk.check_val("sd request count", 32'd0, u_chk.request_count());
		osd_status = 1'b0;
		r = next_rand();
		model_mem[r[12:0]] = r[23:16];
		wb_access(1'b1, r[12:0], r[23:16], rdat);
		u_chk.check_val("sav_pending", 32'd1, sav_pending);
		osd_status = 1'b1;
		wait_busy(1'b1, IDLE_CYCLES, "busy to rise after the menu opened");
		u_chk.check_val("sav_pending", 32'd0, sav_pending);
		wait_busy(1'b0, XFER_TIMEOUT, "the autosave to finish");
		u_chk.check_requests(1'b0);
		osd_status = 1'b0;
		u_chk.end_test();

		u_chk.report_counts();
		if (u_chk.errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// whole run limit
	initial begin
		#2_000_000;
		$display("the simulation did not finish within the time limit");
		$display("test failed");
		$finish;
	end
endmodule

// ==== sources.f ====
+incdir+src
src/bk_pkg.sv
src/bk_mem.sv
src/bk_trigger.sv
src/bk_sector_seq.sv
src/bk_save_top.sv
verif/clk_gen.sv
verif/bk_checker.sv
verif/tb_top.sv

// ==== Bender.yml ====
package:
  name: bk_save

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/bk_pkg.sv
      - src/bk_mem.sv
      - src/bk_trigger.sv
      - src/bk_sector_seq.sv
      - src/bk_save_top.sv
  - target: simulation
    files:
      - verif/clk_gen.sv
      - verif/bk_checker.sv
      - verif/tb_top.sv
